//--- flist.f
+incdir+.
lau_pkg.sv
lau_stream_if.sv
lau_prefix_and_or.sv
lau_add_c.sv
lau_pipe_reg.sv
lau_addsub_unit.sv
lau_top.sv
tb_lau_top.sv

//--- Makefile
# verilator build and run for the add/subtract unit testbench
SIM     = verilator
FLAGS   = --binary --timing -j 0
TOP     = tb_lau_top
FLIST   = flist.f
OBJ_DIR = obj_dir

SOURCES = $(shell grep -v '^+' $(FLIST)) lau_defines.svh
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass is decided by the pass line in the simulator output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_lau_top.sv
// testbench for the add/subtract unit, reference model and in-order result checker
`timescale 1ns/1ps
`default_nettype none

`include "lau_defines.svh"

module tb_lau_top;

	localparam int W = `LAU_WIDTH;
	localparam int timeout_cycles = 2000; // per wait loop

	logic         clk;
	logic         rst_n;
	logic         in_valid;
	logic         in_ready;
	logic [W-1:0] in_a;
	logic [W-1:0] in_b;
	lau_pkg::op_e in_op;
	logic         in_cin;
	logic         out_valid;
	logic         out_ready;
	logic [W-1:0] out_sum;
	logic         out_carry;
	logic         out_zero;
	logic         out_negative;
	logic         out_overflow;

	lau_pkg::res_t exp_q[$]; // expected results, oldest first
	int            acc_q[$]; // cycle of each accepted request
	int            cyc;          // free running edge count
	logic [1:0]    ready_mode;   // 0 low, 1 high, 2 random
	logic          exact_latency;
	string         test_name;

	lau_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_a(in_a),
		.in_b(in_b),
		.in_op(in_op),
		.in_cin(in_cin),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_sum(out_sum),
		.out_carry(out_carry),
		.out_zero(out_zero),
		.out_negative(out_negative),
		.out_overflow(out_overflow)
	);

	always #10 clk = ~clk; // 20 ns period

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			stop_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual));
		end
	endtask

	// expected sum and flags from wide signed and unsigned arithmetic
	function automatic lau_pkg::res_t expected_result(input logic [W-1:0] a, input logic [W-1:0] b,
		input lau_pkg::op_e op, input logic cin);
		longint        ua, ub, sa, sb, c, u, s, lim;
		lau_pkg::res_t r;
		ua  = longint'(a); // zero extended
		ub  = longint'(b);
		sa  = longint'($signed(a));
		sb  = longint'($signed(b));
		lim = longint'(1) << W;
		c   = (op == lau_pkg::OP_ADC || op == lau_pkg::OP_SBB) ? longint'(cin) : 0;
		if (op == lau_pkg::OP_SUB || op == lau_pkg::OP_SBB) begin
			u       = ua - ub - c; // c is the borrow here
			s       = sa - sb - c;
			r.carry = (u >= 0);    // set when no borrow
		end else begin
			u       = ua + ub + c;
			s       = sa + sb + c;
			r.carry = (u >= lim);
		end
		r.sum      = u[W-1:0];
		r.zero     = (r.sum == '0);
		r.negative = r.sum[W-1];
		r.overflow = (s > lim / 2 - 1) || (s < -(lim / 2)); // outside signed range
		return r;
	endfunction

	function automatic logic [W-1:0] random_operand();
		logic [31:0] r;
		r = $urandom;
		return r[W-1:0];
	endfunction

	function automatic lau_pkg::op_e random_op();
		logic [31:0] r;
		r = $urandom;
		return lau_pkg::op_e'(r[1:0]);
	endfunction

	function automatic logic random_bit();
		logic [31:0] r;
		r = $urandom;
		return r[0];
	endfunction

	// out_ready driver, mode changes land one edge later
	always @(posedge clk) begin
		case (ready_mode)
			2'd0:    out_ready <= 1'b0;
			2'd1:    out_ready <= 1'b1;
			default: out_ready <= ($urandom_range(0, 9) < 6); // ~60% ready
		endcase
	end

	// input handshakes push expectations, output handshakes compare
	always @(posedge clk) begin : compare
		lau_pkg::res_t want;
		int            accepted_at;
		cyc <= cyc + 1;
		if (rst_n) begin
			if (in_valid && in_ready) begin
				exp_q.push_back(expected_result(in_a, in_b, in_op, in_cin));
				acc_q.push_back(cyc);
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					stop_run("a result came out with no request outstanding");
				end else begin
					want        = exp_q.pop_front();
					accepted_at = acc_q.pop_front();
					check_value({test_name, " sum"}, 32'(want.sum), 32'(out_sum));
					check_value({test_name, " carry"}, 32'(want.carry), 32'(out_carry));
					check_value({test_name, " zero"}, 32'(want.zero), 32'(out_zero));
					check_value({test_name, " negative"}, 32'(want.negative), 32'(out_negative));
					check_value({test_name, " overflow"}, 32'(want.overflow), 32'(out_overflow));
					if (exact_latency) begin
						check_value({test_name, " latency"}, 32'd2, 32'(cyc - accepted_at));
					end
				end
			end
		end
	end

	// present one request, return once it is taken
	task automatic drive_request(input logic [W-1:0] a, input logic [W-1:0] b,
		input lau_pkg::op_e op, input logic cin, output int waits);
		logic took;
		in_valid <= 1'b1;
		in_a     <= a;
		in_b     <= b;
		in_op    <= op;
		in_cin   <= cin;
		waits = 0;
		took  = 1'b0;
		while (!took && waits < timeout_cycles) begin
			@(posedge clk);
			took = in_ready; // valid is high here
			waits++;
		end
		if (!took) stop_run("timed out waiting for in_ready");
	endtask

	// wait until every accepted item has come out
	task automatic drain();
		int n;
		in_valid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while ((exp_q.size() != 0 || out_valid) && n < timeout_cycles);
		if (exp_q.size() != 0 || out_valid) stop_run("timed out waiting for results to drain");
		@(posedge clk);
	endtask

	task automatic corner_test();
		logic [W-1:0] corner [0:4];
		int           waits;
		test_name <= "corner";
		corner[0] = '0;
		corner[1] = '1;
		corner[2] = {1'b1, {(W-1){1'b0}}}; // most negative
		corner[3] = {1'b0, {(W-1){1'b1}}}; // most positive
		corner[4] = random_operand();
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin // i == j gives equal operands
				for (int o = 0; o < 4; o++) begin
					drive_request(corner[i], corner[j], lau_pkg::op_e'(o[1:0]), 1'b0, waits);
					drive_request(corner[i], corner[j], lau_pkg::op_e'(o[1:0]), 1'b1, waits);
				end
			end
		end
		drain();
	endtask

	task automatic stream_test();
		int waits;
		test_name     <= "stream";
		exact_latency <= 1'b1;
		for (int i = 0; i < 24; i++) begin
			drive_request(random_operand(), random_operand(), random_op(), random_bit(), waits);
			check_value("stream accept cycles", 32'd1, 32'(waits)); // one per cycle
		end
		drain();
		exact_latency <= 1'b0;
	endtask

	task automatic random_test();
		int waits;
		test_name  <= "random";
		ready_mode <= 2'd2;
		for (int i = 0; i < 500; i++) begin
			if ($urandom_range(0, 3) == 0) begin
				in_valid <= 1'b0; // idle gap
				repeat ($urandom_range(1, 3)) @(posedge clk);
			end
			drive_request(random_operand(), random_operand(), random_op(), random_bit(), waits);
		end
		drain();
		ready_mode <= 2'd1;
		@(posedge clk);
	endtask

	task automatic stall_test();
		int   accepted;
		int   n;
		logic took;
		test_name  <= "stall";
		ready_mode <= 2'd0;
		@(posedge clk); // out_ready low from here
		accepted = 0;
		took     = 1'b1;
		while (took && accepted <= 2) begin
			in_valid <= 1'b1;
			in_a     <= random_operand();
			in_b     <= random_operand();
			in_op    <= random_op();
			in_cin   <= random_bit();
			@(posedge clk);
			took = in_ready;
			if (took) accepted++;
		end
		check_value("stall accepted", 32'd2, 32'(accepted)); // both stages full
		repeat (3) begin
			@(posedge clk);
			check_value("stall in_ready", 32'd0, 32'(in_ready));
		end
		ready_mode <= 2'd1;
		n    = 0;
		took = 1'b0;
		while (!took && n < timeout_cycles) begin // pending item held
			@(posedge clk);
			took = in_ready;
			n++;
		end
		if (!took) stop_run("timed out waiting for in_ready after the stall");
		drain();
	endtask

	initial begin : main
		void'($urandom(32'h0adde1ac));
		clk           = 1'b0;
		rst_n         = 1'b0;
		in_valid      = 1'b0;
		in_a          = '0;
		in_b          = '0;
		in_op         = lau_pkg::OP_ADD;
		in_cin        = 1'b0;
		out_ready     = 1'b0; // low so in_ready hangs on the cleared valid bits
		ready_mode    = 2'd0;
		exact_latency = 1'b0;
		test_name     = "reset";
		cyc           = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("reset in_ready", 32'd1, 32'(in_ready));
		check_value("reset out_valid", 32'd0, 32'(out_valid));
		@(posedge clk);
		ready_mode <= 2'd1;
		corner_test();
		stream_test();
		random_test();
		stall_test();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- lau_top.sv
// add/subtract unit top with registered input and output stages on plain ports
`timescale 1ns/1ps
`default_nettype none

`include "lau_defines.svh"

module lau_top #(
	parameter lau_pkg::speed_e speed = `LAU_SPEED // adder prefix structure
) (
	input  logic                  clk,
	input  logic                  rst_n, // sync, active low
	// request side
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [`LAU_WIDTH-1:0] in_a,
	input  logic [`LAU_WIDTH-1:0] in_b,
	input  lau_pkg::op_e          in_op,
	input  logic                  in_cin, // carry or borrow
	// result side
	output logic                  out_valid,
	input  logic                  out_ready,
	output logic [`LAU_WIDTH-1:0] out_sum,
	output logic                  out_carry,
	output logic                  out_zero,
	output logic                  out_negative,
	output logic                  out_overflow
);

	lau_stream_if #(.payload_t(lau_pkg::req_t)) in_s ();  // ports into input reg
	lau_stream_if #(.payload_t(lau_pkg::req_t)) req_s (); // input reg to arithmetic
	lau_stream_if #(.payload_t(lau_pkg::res_t)) res_s (); // arithmetic to output reg
	lau_stream_if #(.payload_t(lau_pkg::res_t)) out_s (); // output reg to ports

	// pack plain inputs
	assign in_s.valid = in_valid;
	assign in_s.data  = '{a: in_a, b: in_b, op: in_op, cin: in_cin};
	assign in_ready   = in_s.ready;

	// stage 1, request register
	lau_pipe_reg #(
		.payload_t(lau_pkg::req_t)
	) in_reg (
		.clk(clk),
		.rst_n(rst_n),
		.in(in_s),
		.out(req_s)
	);

	// zero-cycle arithmetic between the registers
	lau_addsub_unit #(
		.speed(speed)
	) alu (
		.req(req_s),
		.res(res_s)
	);

	// stage 2, result register
	lau_pipe_reg #(
		.payload_t(lau_pkg::res_t)
	) out_reg (
		.clk(clk),
		.rst_n(rst_n),
		.in(res_s),
		.out(out_s)
	);

	// unpack result
	assign out_s.ready  = out_ready;
	assign out_valid    = out_s.valid;
	assign out_sum      = out_s.data.sum;
	assign out_carry    = out_s.data.carry;
	assign out_zero     = out_s.data.zero;
	assign out_negative = out_s.data.negative;
	assign out_overflow = out_s.data.overflow;

endmodule

`default_nettype wire

//--- lau_addsub_unit.sv
// combinational add/subtract stage mapping requests to sum and flags
`timescale 1ns/1ps
`default_nettype none

module lau_addsub_unit #(
	parameter lau_pkg::speed_e speed = lau_pkg::FAST // adder prefix structure
) (
	lau_stream_if.snk req, // requests in
	lau_stream_if.src res  // results out
);

	lau_pkg::req_t rq; // unpacked request
	lau_pkg::res_t rs; // assembled result

	localparam int width = $bits(rq.a);

	logic             sub;   // subtract form
	logic             ci;    // adder carry in
	logic [width-1:0] b_eff; // b or its complement
	logic [width-1:0] sum;
	logic             co;

	assign rq = req.data;

	// a - b is a + ~b + 1
	assign sub   = (rq.op == lau_pkg::OP_SUB) || (rq.op == lau_pkg::OP_SBB);
	assign b_eff = sub ? ~rq.b : rq.b;

	always_comb begin
		case (rq.op)
			lau_pkg::OP_ADD: ci = 1'b0;
			lau_pkg::OP_SUB: ci = 1'b1; // two's complement +1
			lau_pkg::OP_ADC: ci = rq.cin;
			default:         ci = ~rq.cin; // sbb, borrow eats the +1
		endcase
	end

	lau_add_c #(
		.width(width),
		.speed(speed)
	) adder (
		.a(rq.a),
		.b(b_eff),
		.ci(ci),
		.s(sum),
		.co(co)
	);

	assign rs.sum      = sum;
	assign rs.carry    = co; // raw carry, no borrow inversion
	assign rs.zero     = ~|sum;
	assign rs.negative = sum[width-1];
	// same-sign addends giving a different-sign sum
	assign rs.overflow = (rq.a[width-1] == b_eff[width-1]) && (sum[width-1] != rq.a[width-1]);

	// handshake passes straight through
	assign res.valid = req.valid;
	assign res.data  = rs;
	assign req.ready = res.ready;

endmodule

`default_nettype wire

//--- lau_pipe_reg.sv
// single-entry valid/ready pipeline register for any payload type
`timescale 1ns/1ps
`default_nettype none

module lau_pipe_reg #(
	parameter type payload_t = logic // stored item type
) (
	input logic     clk,
	input logic     rst_n, // sync, active low
	lau_stream_if.snk in,  // upstream
	lau_stream_if.src out  // downstream
);

	logic     valid_q; // entry occupied
	payload_t data_q;  // held item

	// free slot, or slot drains this cycle
	assign in.ready = ~valid_q | out.ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in.ready) begin
			valid_q <= in.valid; // refill or go empty
		end
	end

	// payload only moves on an accepted beat
	always_ff @(posedge clk) begin
		if (in.valid && in.ready) begin
			data_q <= in.data;
		end
	end

	assign out.valid = valid_q;
	assign out.data  = data_q; // stable while valid and stalled

endmodule

`default_nettype wire

//--- lau_add_c.sv
// carry-lookahead adder with carry in and carry out on a prefix network
`timescale 1ns/1ps
`default_nettype none

module lau_add_c #(
	parameter int              width = 16,           // word width
	parameter lau_pkg::speed_e speed = lau_pkg::FAST // prefix structure
) (
	input  logic [width-1:0] a,  // operands
	input  logic [width-1:0] b,
	input  logic             ci, // carry in
	output logic [width-1:0] s,  // sum
	output logic             co  // carry out
);

	logic [width-1:0] gi, pi; // bit gen/prop into prefix
	logic [width-1:0] go;     // prefix gen, carry out of each bit
	logic [width-1:0] ht;     // half sum a ^ b

	// bit 0 absorbs the carry in as a full adder majority
	assign gi[0] = (a[0] & b[0]) | (a[0] & ci) | (b[0] & ci);
	assign pi[0] = 1'b0; // nothing propagates past bit 0
	assign ht[0] = a[0] ^ b[0];

	for (genvar i = 1; i < width; i++) begin : g_pre
		assign gi[i] = a[i] & b[i];
		assign pi[i] = a[i] | b[i];
		assign ht[i] = ~gi[i] & pi[i]; // xor from and/or
	end

	// group prop out is not needed, carry in already folded
	lau_prefix_and_or #(
		.width(width),
		.speed(speed)
	) prefix (
		.gi(gi),
		.pi(pi),
		.go(go),
		.po()
	);

	assign s  = ht ^ {go[width-2:0], ci}; // carry into bit i is go[i-1]
	assign co = go[width-1];

endmodule

`default_nettype wire

//--- lau_prefix_and_or.sv
// parallel-prefix and-or network for generate/propagate in serial, brent-kung or sklansky form
`timescale 1ns/1ps
`default_nettype none

module lau_prefix_and_or #(
	parameter int              width = 16,           // word width
	parameter lau_pkg::speed_e speed = lau_pkg::FAST // prefix structure
) (
	input  logic [width-1:0] gi, // generate in
	input  logic [width-1:0] pi, // propagate in
	output logic [width-1:0] go, // prefix generate out
	output logic [width-1:0] po  // prefix propagate out
);

	localparam int n = width;
	localparam int m = $clog2(width); // tree depth

	if (speed == lau_pkg::SLOW) begin : g_serial
		// plain ripple chain, n-1 cells deep
		logic [n-1:0] gt, pt;

		assign gt[0] = gi[0];
		assign pt[0] = pi[0];
		for (genvar i = 1; i < n; i++) begin : g_bit
			assign gt[i] = gi[i] | (pi[i] & gt[i-1]); // extend group one bit
			assign pt[i] = pi[i] & pt[i-1];
		end

		assign go = gt;
		assign po = pt;
	end else if (speed == lau_pkg::MEDIUM) begin : g_brent_kung
		// up tree of m levels then down tree of m-1 levels
		localparam int stages = 2 * m - 1;

		logic [n-1:0] gt [0:stages]; // per stage gen
		logic [n-1:0] pt [0:stages]; // per stage prop

		assign gt[0] = gi;
		assign pt[0] = pi;

		// up-sweep, block tops collect their whole block
		for (genvar l = 1; l <= m; l++) begin : g_up
			for (genvar j = 0; j < n; j++) begin : g_bit
				if ((j + 1) % (2 ** l) == 0) begin : g_black
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][j - 2**(l-1)]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][j - 2**(l-1)];
				end else begin : g_white
					assign gt[l][j] = gt[l-1][j]; // pass through
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		// down-sweep, fill the half-block points from completed prefixes
		for (genvar d = 1; d < m; d++) begin : g_down
			localparam int l = m - d; // span level, shrinking
			localparam int s = m + d; // stage index

			for (genvar j = 0; j < n; j++) begin : g_bit
				if (j >= 2 ** l && (j + 1) % (2 ** l) == 2 ** (l - 1)) begin : g_black
					assign gt[s][j] = gt[s-1][j] | (pt[s-1][j] & gt[s-1][j - 2**(l-1)]);
					assign pt[s][j] = pt[s-1][j] & pt[s-1][j - 2**(l-1)];
				end else begin : g_white
					assign gt[s][j] = gt[s-1][j];
					assign pt[s][j] = pt[s-1][j];
				end
			end
		end

		assign go = gt[stages];
		assign po = pt[stages];
	end else begin : g_sklansky
		// divide and conquer, m levels, high fanout
		logic [n-1:0] gt [0:m];
		logic [n-1:0] pt [0:m];

		assign gt[0] = gi;
		assign pt[0] = pi;

		for (genvar l = 1; l <= m; l++) begin : g_lvl
			for (genvar j = 0; j < n; j++) begin : g_bit
				// upper half of each 2**l block takes the lower half's top bit
				if ((j / 2 ** (l - 1)) % 2 == 1) begin : g_black
					localparam int src = (j / 2 ** (l - 1)) * 2 ** (l - 1) - 1;

					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][src]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][src];
				end else begin : g_white
					assign gt[l][j] = gt[l-1][j];
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		assign go = gt[m];
		assign po = pt[m];
	end

endmodule

`default_nettype wire

//--- lau_stream_if.sv
// valid/ready stream interface carrying one payload of any type
`timescale 1ns/1ps
`default_nettype none

interface lau_stream_if #(
	parameter type payload_t = logic // payload carried per beat
) ();

	logic     valid; // data is presented
	logic     ready; // sink can take it
	payload_t data;

	// producer side
	modport src (
		output valid,
		output data,
		input  ready
	);

	// consumer side
	modport snk (
		input  valid,
		input  data,
		output ready
	);

endinterface

`default_nettype wire

//--- lau_pkg.sv
// lau package with speed selection, opcodes and stream payload types
`default_nettype none

`include "lau_defines.svh"

package lau_pkg;

	// prefix structure select
	typedef enum logic [1:0] {
		SLOW   = 2'b00, // serial ripple prefix
		MEDIUM = 2'b01, // brent-kung
		FAST   = 2'b10  // sklansky
	} speed_e;

	// arithmetic operation code
	typedef enum logic [1:0] {
		OP_ADD = 2'b00, // a + b
		OP_SUB = 2'b01, // a - b
		OP_ADC = 2'b10, // a + b + cin
		OP_SBB = 2'b11  // a - b - cin, cin is borrow
	} op_e;

	// request into the unit
	typedef struct packed {
		logic [`LAU_WIDTH-1:0] a; // first operand
		logic [`LAU_WIDTH-1:0] b; // second operand
		op_e                   op;
		logic                  cin; // carry or borrow in
	} req_t;

	// result out of the unit
	// carry is raw adder carry out, so set on sub when no borrow
	typedef struct packed {
		logic [`LAU_WIDTH-1:0] sum;
		logic                  carry;
		logic                  zero;     // sum all zeros
		logic                  negative; // sum msb
		logic                  overflow; // signed overflow
	} res_t;

endpackage

`default_nettype wire

//--- lau_defines.svh
// shared width and prefix speed macros for the add/subtract unit
`ifndef LAU_DEFINES_SVH
`define LAU_DEFINES_SVH

// operand and result width in bits
// prefix trees assume at least 2 bits
`define LAU_WIDTH 16

// default carry-lookahead structure for the top level
// one of lau_pkg::SLOW / MEDIUM / FAST
`define LAU_SPEED lau_pkg::FAST

`endif
